/* int_rs_pkg.sv */
package int_rs_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int XLEN          = 32;
    localparam int PHYS_TAG_W    = 6;
    localparam int ROB_ID_W      = 5;
    localparam int NUM_PHYS_REGS = 1 << PHYS_TAG_W;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;
    typedef logic [ROB_ID_W-1:0]   rob_id_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT
    } alu_op_t;

    ////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////

    // renamed op as it arrives from rename
    typedef struct packed {
        rob_id_t   rob_id;
        alu_op_t   op;
        phys_tag_t rs1_tag;
        phys_tag_t rs2_tag;
        phys_tag_t rd_tag;
        logic      use_imm;
        data_t     imm;
    } dispatch_uop_t;

    typedef struct packed {
        dispatch_uop_t uop;
        logic          rs1_ready;
        logic          rs2_ready;
    } rs_entry_t;

    // selected op plus its register file operands
    typedef struct packed {
        rob_id_t   rob_id;
        alu_op_t   op;
        phys_tag_t rd_tag;
        logic      use_imm;
        data_t     imm;
        data_t     rs1_value;
        data_t     rs2_value;
    } issue_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        phys_tag_t tag;
        data_t     value;
    } cdb_t;

endpackage

/* dispatch_stage.sv */
`timescale 1ns/10ps

module dispatch_stage (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     in_valid,
    input  int_rs_pkg::dispatch_uop_t in_uop,
    output logic                     in_ready,

    output logic                     alloc_valid,
    output int_rs_pkg::rs_entry_t    alloc_entry,
    input  logic                     alloc_ready,

    input  int_rs_pkg::cdb_t         cdb
);

    // one bit per physical register, set while a producer is in flight
    logic [int_rs_pkg::NUM_PHYS_REGS-1:0] busy;

    logic accept;
    logic rs1_fwd;
    logic rs2_fwd;

    assign in_ready    = alloc_ready;
    assign alloc_valid = in_valid;
    assign accept      = in_valid && alloc_ready;

    // result on the bus this cycle counts as ready
    assign rs1_fwd = cdb.valid && (cdb.tag == in_uop.rs1_tag);
    assign rs2_fwd = cdb.valid && (cdb.tag == in_uop.rs2_tag);

    always_comb begin
        alloc_entry.uop       = in_uop;
        alloc_entry.rs1_ready = !busy[in_uop.rs1_tag] || rs1_fwd;
        // immediate form never waits on rs2
        alloc_entry.rs2_ready = in_uop.use_imm || !busy[in_uop.rs2_tag] || rs2_fwd;
    end

    ////////////////////////////////////////
    // busy table
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (cdb.valid) begin
                busy[cdb.tag] <= 1'b0;
            end
            // new producer wins over an old broadcast to the same tag
            if (accept) begin
                busy[in_uop.rd_tag] <= 1'b1;
            end
        end
    end

endmodule

/* int_rs_queue.sv */
`timescale 1ns/10ps

module int_rs_queue #(
    parameter int RS_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   alloc_valid,
    input  int_rs_pkg::rs_entry_t  alloc_entry,
    output logic                   alloc_ready,

    input  int_rs_pkg::cdb_t       cdb,

    output int_rs_pkg::phys_tag_t  rs1_tag,
    output int_rs_pkg::phys_tag_t  rs2_tag,
    input  int_rs_pkg::data_t      rs1_value,
    input  int_rs_pkg::data_t      rs2_value,

    output logic                   issue_valid,
    output int_rs_pkg::issue_t     issue
);

    localparam int IDX_W = $clog2(RS_DEPTH);
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    // index 0 holds the oldest op
    logic [RS_DEPTH-1:0]   rs_valid;
    int_rs_pkg::rs_entry_t entries     [RS_DEPTH];
    int_rs_pkg::rs_entry_t nxt_entry   [RS_DEPTH];
    int_rs_pkg::rs_entry_t above_entry [RS_DEPTH];
    logic [RS_DEPTH-1:0]   nxt_valid;
    logic [RS_DEPTH-1:0]   above_valid;
    logic [RS_DEPTH-1:0]   rs_request;

    logic [CNT_W-1:0]      rs_top;
    logic [CNT_W-1:0]      rs_top_next;
    logic [CNT_W-1:0]      free_slots;
    logic [IDX_W-1:0]      issue_idx;
    logic                  push;

    int_rs_pkg::rs_entry_t sel_entry;

    ////////////////////////////////////////
    // compression sources
    ////////////////////////////////////////
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_above
        if (i < RS_DEPTH - 1) begin : g_mid
            assign above_entry[i] = entries[i+1];
            assign above_valid[i] = rs_valid[i+1];
        end else begin : g_last
            assign above_entry[i] = '0;
            assign above_valid[i] = 1'b0;
        end
        assign rs_request[i] = rs_valid[i] && entries[i].rs1_ready && entries[i].rs2_ready;
    end

    ////////////////////////////////////////
    // select, oldest ready wins
    ////////////////////////////////////////
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (rs_request[i]) begin
                issue_valid = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    assign sel_entry = entries[issue_idx];
    assign rs1_tag   = sel_entry.uop.rs1_tag;
    assign rs2_tag   = sel_entry.uop.rs2_tag;

    always_comb begin
        issue.rob_id    = sel_entry.uop.rob_id;
        issue.op        = sel_entry.uop.op;
        issue.rd_tag    = sel_entry.uop.rd_tag;
        issue.use_imm   = sel_entry.uop.use_imm;
        issue.imm       = sel_entry.uop.imm;
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
    end

    ////////////////////////////////////////
    // free slots and ready
    ////////////////////////////////////////
    always_comb begin
        free_slots = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!rs_valid[i]) begin
                free_slots = free_slots + 1'b1;
            end
        end
    end

    // a slot popped this cycle can take the new op
    assign alloc_ready = (free_slots != '0) || issue_valid;
    assign push        = alloc_valid && alloc_ready;

    ////////////////////////////////////////
    // shift, push and wakeup
    ////////////////////////////////////////
    always_comb begin
        rs_top_next = rs_top;
        if (issue_valid) begin
            rs_top_next = rs_top_next - 1'b1;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            nxt_entry[i] = entries[i];
            nxt_valid[i] = rs_valid[i];
            if (issue_valid && (IDX_W'(i) >= issue_idx)) begin
                nxt_entry[i] = above_entry[i];
                nxt_valid[i] = above_valid[i];
            end
            if (push && (CNT_W'(i) == rs_top_next)) begin
                nxt_entry[i] = alloc_entry;
                nxt_valid[i] = 1'b1;
            end
            // moving entries snoop the bus too
            if (cdb.valid && (cdb.tag == nxt_entry[i].uop.rs1_tag)) begin
                nxt_entry[i].rs1_ready = 1'b1;
            end
            if (cdb.valid && (cdb.tag == nxt_entry[i].uop.rs2_tag)) begin
                nxt_entry[i].rs2_ready = 1'b1;
            end
        end
        if (push) begin
            rs_top_next = rs_top_next + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs_valid <= '0;
            rs_top   <= '0;
        end else begin
            rs_valid <= nxt_valid;
            rs_top   <= rs_top_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entries[i] <= nxt_entry[i];
        end
    end

endmodule

/* phys_regfile.sv */
`timescale 1ns/10ps

module phys_regfile (
    input  logic                  clk,
    input  logic                  rst,

    input  int_rs_pkg::phys_tag_t rs1_tag,
    input  int_rs_pkg::phys_tag_t rs2_tag,
    output int_rs_pkg::data_t     rs1_value,
    output int_rs_pkg::data_t     rs2_value,

    input  int_rs_pkg::cdb_t      cdb
);

    int_rs_pkg::data_t regs [int_rs_pkg::NUM_PHYS_REGS];

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////

    // no bypass, consumers issue after the write edge
    assign rs1_value = regs[rs1_tag];
    assign rs2_value = regs[rs2_tag];

    ////////////////////////////////////////
    // writeback from the cdb
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < int_rs_pkg::NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb.valid) begin
            regs[cdb.tag] <= cdb.value;
        end
    end

endmodule

/* exec_alu.sv */
`timescale 1ns/10ps

module exec_alu (
    input  logic               clk,
    input  logic               rst,

    input  logic               issue_valid,
    input  int_rs_pkg::issue_t issue,

    output int_rs_pkg::cdb_t   cdb
);

    int_rs_pkg::data_t op_a;
    int_rs_pkg::data_t op_b;
    int_rs_pkg::data_t result;
    logic [4:0]        shamt;

    assign op_a  = issue.rs1_value;
    assign op_b  = issue.use_imm ? issue.imm : issue.rs2_value;
    // only the low 5 bits count as shift amount
    assign shamt = op_b[4:0];

    ////////////////////////////////////////
    // operation
    ////////////////////////////////////////
    always_comb begin
        case (issue.op)
            int_rs_pkg::ADD: result = op_a + op_b;
            int_rs_pkg::SUB: result = op_a - op_b;
            int_rs_pkg::AND: result = op_a & op_b;
            int_rs_pkg::OR:  result = op_a | op_b;
            int_rs_pkg::XOR: result = op_a ^ op_b;
            int_rs_pkg::SLL: result = op_a << shamt;
            int_rs_pkg::SRL: result = op_a >> shamt;
            int_rs_pkg::SLT: begin
                result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            end
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////
    // result register onto the cdb
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_valid;
        end
        if (issue_valid) begin
            cdb.rob_id <= issue.rob_id;
            cdb.tag    <= issue.rd_tag;
            cdb.value  <= result;
        end
    end

endmodule

/* int_rs_top.sv */
`timescale 1ns/10ps

module int_rs_top #(
    parameter int RS_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      in_valid,
    input  int_rs_pkg::dispatch_uop_t in_uop,
    output logic                      in_ready,

    output int_rs_pkg::cdb_t          cdb
);

    logic                  alloc_valid;
    logic                  alloc_ready;
    int_rs_pkg::rs_entry_t alloc_entry;

    int_rs_pkg::phys_tag_t rs1_tag;
    int_rs_pkg::phys_tag_t rs2_tag;
    int_rs_pkg::data_t     rs1_value;
    int_rs_pkg::data_t     rs2_value;

    logic                  issue_valid;
    int_rs_pkg::issue_t    issue;

    dispatch_stage i_dispatch_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_uop      (in_uop),
        .in_ready    (in_ready),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .alloc_ready (alloc_ready),
        .cdb         (cdb)
    );

    int_rs_queue #(
        .RS_DEPTH (RS_DEPTH)
    ) i_int_rs_queue (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .alloc_ready (alloc_ready),
        .cdb         (cdb),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    phys_regfile i_phys_regfile (
        .clk       (clk),
        .rst       (rst),
        .rs1_tag   (rs1_tag),
        .rs2_tag   (rs2_tag),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .cdb       (cdb)
    );

    exec_alu i_exec_alu (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb         (cdb)
    );

endmodule

/* tb_int_rs_assert.sv */
`timescale 1ns/10ps

module rs_queue_props #(
    parameter int RS_DEPTH = 8
) (
    input logic                clk,
    input logic                rst,
    input logic [RS_DEPTH-1:0] rs_valid,
    input logic                issue_valid,
    input logic                alloc_ready
);

    // nothing to select from an empty queue
    no_issue_when_empty: assert property (@(posedge clk) disable iff (rst)
        (rs_valid == '0) |-> !issue_valid)
        else $error("issue_valid high while the queue is empty");

    full_blocks_alloc: assert property (@(posedge clk) disable iff (rst)
        (&rs_valid && !issue_valid) |-> !alloc_ready)
        else $error("alloc_ready high with every slot valid and no issue");

    quiet_after_reset: assert property (@(posedge clk) rst |=> !issue_valid)
        else $error("issue_valid high in the cycle after reset");

endmodule

bind int_rs_queue rs_queue_props #(
    .RS_DEPTH (RS_DEPTH)
) i_rs_queue_props (
    .clk         (clk),
    .rst         (rst),
    .rs_valid    (rs_valid),
    .issue_valid (issue_valid),
    .alloc_ready (alloc_ready)
);

/* tb_int_rs.sv */
`timescale 1ns/10ps

module tb_int_rs;

    localparam int SEED       = 32'h3daf_0e26;
    localparam int N_SETUP    = 6;
    localparam int N_OPCODE   = 32;
    localparam int N_BURST    = 16;
    localparam int N_CHAIN    = 24;
    localparam int N_PRESSURE = 40;
    localparam int N_RANDOM   = 200;
    localparam int TOTAL_OPS  = N_SETUP + N_OPCODE + N_BURST + N_CHAIN + N_PRESSURE + N_RANDOM;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 8 + 1000;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    int_rs_pkg::dispatch_uop_t in_uop;
    int_rs_pkg::cdb_t          cdb;

    ////////////////////////////////////////
    // rename and scoreboard state
    ////////////////////////////////////////
    int_rs_pkg::data_t     model     [64];
    bit                    tag_busy  [64];
    int                    writer_seq [64];
    int_rs_pkg::data_t     exp_value [32];
    int_rs_pkg::phys_tag_t exp_tag   [32];
    int                    op_seq    [32];
    int                    dep1      [32];
    int                    dep2      [32];
    bit                    pending   [32];
    bit                    seq_done  [int];
    int_rs_pkg::phys_tag_t free_pool [$];
    int_rs_pkg::phys_tag_t recent    [$];
    int_rs_pkg::rob_id_t   retired   [$];
    int_rs_pkg::rob_id_t   next_rob  = '0;
    int  seq_cnt   = 0;
    int  n_sent    = 0;
    int  n_retired = 0;
    int  n_pending = 0;
    int  n_cdb     = 0;
    int  n_tests   = 0;
    int  errors    = 0;
    bit  stall_seen = 1'b0;

    int_rs_top i_int_rs_top (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_uop   (in_uop),
        .in_ready (in_ready),
        .cdb      (cdb)
    );

    always #20 clk = ~clk;

    // expected result straight from the ALU rules
    function automatic int_rs_pkg::data_t ref_alu(input int_rs_pkg::alu_op_t op,
                                                  input int_rs_pkg::data_t a,
                                                  input int_rs_pkg::data_t b);
        int sh;
        sh = int'(b & 32'h1f);
        case (op)
            int_rs_pkg::ADD: return a + b;
            int_rs_pkg::SUB: return a - b;
            int_rs_pkg::AND: return a & b;
            int_rs_pkg::OR:  return a | b;
            int_rs_pkg::XOR: return a ^ b;
            int_rs_pkg::SLL: return a << sh;
            int_rs_pkg::SRL: return a >> sh;
            // with differing signs the negative one is smaller
            default: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        endcase
    endfunction

    function automatic int_rs_pkg::phys_tag_t pick_ready_tag();
        int_rs_pkg::phys_tag_t t;
        t = int_rs_pkg::phys_tag_t'($urandom_range(63));
        while (tag_busy[t]) begin
            t = int_rs_pkg::phys_tag_t'($urandom_range(63));
        end
        return t;
    endfunction

    function automatic int_rs_pkg::alu_op_t pick_op();
        return int_rs_pkg::alu_op_t'($urandom_range(7));
    endfunction

    ////////////////////////////////////////
    // dispatch with renaming
    ////////////////////////////////////////
    task automatic send_uop(input int_rs_pkg::alu_op_t op, input int_rs_pkg::phys_tag_t rs1,
                            input int_rs_pkg::phys_tag_t rs2, input logic use_imm,
                            input int_rs_pkg::data_t imm);
        int_rs_pkg::dispatch_uop_t u;
        logic taken;
        while (pending[next_rob]) begin
            @(posedge clk);
            #2;
        end
        u.rob_id  = next_rob;
        u.op      = op;
        u.rs1_tag = rs1;
        u.rs2_tag = rs2;
        u.rd_tag  = free_pool.pop_front();
        u.use_imm = use_imm;
        u.imm     = imm;
        exp_value[next_rob] = ref_alu(op, model[rs1], use_imm ? imm : model[rs2]);
        exp_tag[next_rob]   = u.rd_tag;
        op_seq[next_rob]    = seq_cnt;
        dep1[next_rob] = tag_busy[rs1] ? writer_seq[rs1] : -1;
        dep2[next_rob] = (!use_imm && tag_busy[rs2]) ? writer_seq[rs2] : -1;
        in_valid = 1'b1;
        in_uop   = u;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            stall_seen |= !taken;
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
        model[u.rd_tag]      = exp_value[next_rob];
        tag_busy[u.rd_tag]   = 1'b1;
        writer_seq[u.rd_tag] = seq_cnt;
        pending[next_rob]    = 1'b1;
        recent.push_back(u.rd_tag);
        if (recent.size() > 6) begin
            void'(recent.pop_front());
        end
        seq_cnt++;
        n_sent++;
        n_pending++;
        next_rob = next_rob + 1'b1;
    endtask

    // each op takes the previous rd as rs1
    task automatic send_chain(input int n, input bit reg_form);
        int_rs_pkg::phys_tag_t prev;
        prev = pick_ready_tag();
        for (int i = 0; i < n; i++) begin
            send_uop(pick_op(), prev, pick_ready_tag(), !reg_form, $urandom());
            prev = recent[$];
        end
    endtask

    task automatic wait_drain();
        while (n_pending != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        wait_drain();
        n_tests++;
        $display("test %-12s done, %0d ops retired so far, %0d errors", name, n_retired,
                 errors - err_start);
    endtask

    ////////////////////////////////////////
    // checker on every broadcast
    ////////////////////////////////////////
    task automatic check_broadcast();
        int_rs_pkg::rob_id_t r;
        r = cdb.rob_id;
        assert (pending[r]) else begin
            $display("[ERROR] %0t rob_id %0d broadcast while not outstanding", $time, r);
            errors++;
        end
        if (pending[r]) begin
            assert (cdb.value == exp_value[r] && cdb.tag == exp_tag[r]) else begin
                $display("[ERROR] %0t rob_id %0d tag %0d value %h, expected tag %0d value %h",
                         $time, r, cdb.tag, cdb.value, exp_tag[r], exp_value[r]);
                errors++;
            end
            assert ((dep1[r] < 0 || seq_done.exists(dep1[r])) &&
                    (dep2[r] < 0 || seq_done.exists(dep2[r]))) else begin
                $display("[ERROR] %0t rob_id %0d broadcast before its producer", $time, r);
                errors++;
            end
            seq_done[op_seq[r]] = 1'b1;
            pending[r] = 1'b0;
            tag_busy[exp_tag[r]] = 1'b0;
            free_pool.push_back(exp_tag[r]);
            retired.push_back(r);
            n_pending--;
            n_retired++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && cdb.valid) begin
            n_cdb++;
            check_broadcast();
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, ops still outstanding: %0d", TIMEOUT_CYCLES,
                 n_pending);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    initial begin
        int e0;
        int first;
        int_rs_pkg::phys_tag_t base [6];
        int_rs_pkg::rob_id_t   burst_rob [$];
        int_rs_pkg::data_t     setup_imm [6] = '{32'hffff_fff3, 32'h8000_0000, 32'h7fff_ffff,
                                                 32'd12345, 32'h0000_00f0, 32'hdead_beef};
        void'($urandom(SEED));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_uop   = '0;
        for (int i = 0; i < 64; i++) begin
            model[i]    = '0;
            tag_busy[i] = 1'b0;
            free_pool.push_back(int_rs_pkg::phys_tag_t'(i));
        end
        for (int i = 0; i < 32; i++) begin
            pending[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // idle after reset
        e0 = errors;
        repeat (5) begin
            @(negedge clk);
            assert (in_ready === 1'b1 && cdb.valid === 1'b0) else begin
                $display("[ERROR] %0t after reset in_ready %b cdb.valid %b", $time, in_ready,
                         cdb.valid);
                errors++;
            end
        end
        @(posedge clk);
        #2;
        finish_test("reset", e0);

        // every opcode in register and immediate form
        e0 = errors;
        for (int i = 0; i < N_SETUP; i++) begin
            send_uop(int_rs_pkg::ADD, pick_ready_tag(), '0, 1'b1, setup_imm[i]);
            base[i] = recent[$];
        end
        finish_test("setup", e0);
        for (int k = 0; k < 2; k++) begin
            for (int o = 0; o < 8; o++) begin
                send_uop(int_rs_pkg::alu_op_t'(o), base[(o + k) % 6], base[(o + k + 3) % 6],
                         1'b0, '0);
                send_uop(int_rs_pkg::alu_op_t'(o), base[(o + 2 * k) % 6], '0, 1'b1,
                         (k == 0) ? 32'd33 + 32'(o * 4) : $urandom());
            end
        end
        finish_test("opcodes", e0);

        // ready burst leaves in dispatch order
        e0 = errors;
        first = retired.size();
        for (int i = 0; i < N_BURST; i++) begin
            burst_rob.push_back(next_rob);
            send_uop(pick_op(), pick_ready_tag(), pick_ready_tag(), $urandom_range(1) == 1,
                     $urandom());
        end
        wait_drain();
        for (int i = 0; i < N_BURST; i++) begin
            assert (retired[first + i] == burst_rob[i]) else begin
                $display("[ERROR] %0t burst slot %0d retired rob_id %0d, expected %0d", $time,
                         i, retired[first + i], burst_rob[i]);
                errors++;
            end
        end
        finish_test("burst", e0);

        e0 = errors;
        send_chain(N_CHAIN, 1'b1);
        finish_test("chain", e0);

        e0 = errors;
        first = n_cdb;
        stall_seen = 1'b0;
        send_chain(N_PRESSURE, 1'b0);
        wait_drain();
        assert (stall_seen && n_cdb - first == N_PRESSURE) else begin
            $display("back-pressure test failed, stall seen %0b, %0d broadcasts for %0d ops",
                     stall_seen, n_cdb - first, N_PRESSURE);
            errors++;
        end
        finish_test("pressure", e0);

        // random mix with gaps on in_valid
        e0 = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            if ($urandom_range(3) == 0) begin
                repeat ($urandom_range(3, 1)) begin
                    @(posedge clk);
                    #2;
                end
            end
            send_uop(pick_op(), recent[$urandom_range(recent.size() - 1)],
                     recent[$urandom_range(recent.size() - 1)], $urandom_range(1) == 1,
                     ($urandom_range(1) == 1) ? 32'($urandom_range(63)) : $urandom());
        end
        finish_test("random", e0);

        assert (n_pending == 0 && n_cdb == n_sent) else begin
            $display("%0d ops sent but %0d broadcasts seen", n_sent, n_cdb);
            errors++;
        end
        $display("tests %0d, ops sent %0d, retired %0d, errors %0d", n_tests, n_sent,
                 n_retired, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* int_rs.f */
int_rs_pkg.sv
dispatch_stage.sv
int_rs_queue.sv
phys_regfile.sv
exec_alu.sv
int_rs_top.sv
tb_int_rs_assert.sv
tb_int_rs.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_int_rs
FILELIST  ?= int_rs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  := Some tests failed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	fi; \
	echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
